//--- common/llc_pkg.sv
package llc_pkg;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////

  // full byte address
  localparam int unsigned ADDR_W       = 32;
  // 64 byte lines
  localparam int unsigned OFFSET_W     = 6;
  // 16 sets
  localparam int unsigned INDEX_W      = 4;
  // whatever is left above index and offset
  localparam int unsigned TAG_W        = ADDR_W - INDEX_W - OFFSET_W;
  localparam int unsigned NUM_SETS     = 1 << INDEX_W;
  localparam int unsigned NUM_WAYS     = 4;

  //////////////////////////////////////////////////////////////////////
  // descriptor ids and bookkeeping
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ID_W         = 2;
  localparam int unsigned NUM_IDS      = 1 << ID_W;
  // outstanding misses per id
  localparam int unsigned CNT_W        = 3;
  localparam int unsigned MAX_MISS     = (1 << CNT_W) - 1;
  // lines that can be locked downstream at once
  localparam int unsigned LOCK_ENTRIES = 4;

  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;
  // one bit per way, one-hot when it names a line
  typedef logic [NUM_WAYS-1:0] way_t;
  typedef logic [ID_W-1:0]     id_t;
  typedef logic [CNT_W-1:0]    cnt_t;

  // address seen as a flat word or split into its cache fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      tag_t                tag;
      index_t              index;
      logic [OFFSET_W-1:0] offset;
    } fields;
  } addr_t;

endpackage

//--- common/lock_if.sv
`timescale 1ns/10ps

interface lock_if;
  import llc_pkg::*;

  // line of the descriptor sitting in the unit
  index_t chk_index;
  way_t   chk_way;
  // single cycle pulse, line goes into the table
  logic   lock_req;
  // combinational answer for the checked line
  logic   locked;

  modport ctrl (
    output chk_index, chk_way, lock_req,
    input  locked
  );

  modport box (
    input  chk_index, chk_way, lock_req,
    output locked
  );

endinterface

//--- common/miss_cnt_if.sv
`timescale 1ns/10ps

interface miss_cnt_if;
  import llc_pkg::*;

  // count up on every miss side transfer
  logic up_valid;
  id_t  up_id;
  // id of the descriptor in the unit
  id_t  chk_id;
  // that id still has misses in flight
  logic to_miss;
  // that id has no room for another miss
  logic stall;

  modport ctrl (
    output up_valid, up_id, chk_id,
    input  to_miss, stall
  );

  modport cnt (
    input  up_valid, up_id, chk_id,
    output to_miss, stall
  );

endinterface

//--- common/tag_store_if.sv
`timescale 1ns/10ps

interface tag_store_if;
  import llc_pkg::*;

  // lookup request, one per descriptor
  logic   req_valid;
  logic   req_ready;
  index_t req_index;
  tag_t   req_tag;
  // write access, line becomes dirty
  logic   req_write;

  // lookup result, held until taken
  logic   res_valid;
  logic   res_ready;
  logic   res_hit;
  way_t   res_way;
  logic   res_evict;
  tag_t   res_evict_tag;

  modport ctrl (
    output req_valid, req_index, req_tag, req_write, res_ready,
    input  req_ready, res_valid, res_hit, res_way, res_evict, res_evict_tag
  );

  modport store (
    input  req_valid, req_index, req_tag, req_write, res_ready,
    output req_ready, res_valid, res_hit, res_way, res_evict, res_evict_tag
  );

endinterface

//--- rtl/llc_hit_miss.sv
`timescale 1ns/10ps

module llc_hit_miss (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // descriptor in
  input  logic            valid_i,
  output logic            ready_o,
  input  llc_pkg::addr_t  desc_addr_i,
  input  llc_pkg::id_t    desc_id_i,
  input  logic            desc_write_i,
  // descriptor out, shared by both output ports
  output llc_pkg::addr_t  desc_addr_o,
  output llc_pkg::id_t    desc_id_o,
  output logic            desc_write_o,
  output llc_pkg::way_t   desc_way_o,
  output logic            desc_refill_o,
  output logic            desc_evict_o,
  output llc_pkg::tag_t   desc_evict_tag_o,
  output logic            hit_valid_o,
  input  logic            hit_ready_i,
  output logic            miss_valid_o,
  input  logic            miss_ready_i,
  // unlocks from the write and read units
  input  logic            w_unlock_req_i,
  input  llc_pkg::index_t w_unlock_index_i,
  input  llc_pkg::way_t   w_unlock_way_i,
  output logic            w_unlock_gnt_o,
  input  logic            r_unlock_req_i,
  input  llc_pkg::index_t r_unlock_index_i,
  input  llc_pkg::way_t   r_unlock_way_i,
  output logic            r_unlock_gnt_o,
  // a miss has finished downstream
  input  logic            cnt_down_valid_i,
  input  llc_pkg::id_t    cnt_down_id_i
);

  tag_store_if ts_bus ();
  lock_if      lk_bus ();
  miss_cnt_if  mc_bus ();

  // descriptor holding register and routing
  llc_hit_miss_ctrl i_ctrl (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .valid_i          ( valid_i          ),
    .ready_o          ( ready_o          ),
    .desc_addr_i      ( desc_addr_i      ),
    .desc_id_i        ( desc_id_i        ),
    .desc_write_i     ( desc_write_i     ),
    .desc_addr_o      ( desc_addr_o      ),
    .desc_id_o        ( desc_id_o        ),
    .desc_write_o     ( desc_write_o     ),
    .desc_way_o       ( desc_way_o       ),
    .desc_refill_o    ( desc_refill_o    ),
    .desc_evict_o     ( desc_evict_o     ),
    .desc_evict_tag_o ( desc_evict_tag_o ),
    .hit_valid_o      ( hit_valid_o      ),
    .hit_ready_i      ( hit_ready_i      ),
    .miss_valid_o     ( miss_valid_o     ),
    .miss_ready_i     ( miss_ready_i     ),
    .ts               ( ts_bus.ctrl      ),
    .lk               ( lk_bus.ctrl      ),
    .mc               ( mc_bus.ctrl      )
  );

  llc_tag_store i_tag_store (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .ts      ( ts_bus.store )
  );

  llc_lock_box i_lock_box (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .lk               ( lk_bus.box       ),
    .w_unlock_req_i   ( w_unlock_req_i   ),
    .w_unlock_index_i ( w_unlock_index_i ),
    .w_unlock_way_i   ( w_unlock_way_i   ),
    .w_unlock_gnt_o   ( w_unlock_gnt_o   ),
    .r_unlock_req_i   ( r_unlock_req_i   ),
    .r_unlock_index_i ( r_unlock_index_i ),
    .r_unlock_way_i   ( r_unlock_way_i   ),
    .r_unlock_gnt_o   ( r_unlock_gnt_o   )
  );

  llc_miss_counters i_miss_counters (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .mc               ( mc_bus.cnt       ),
    .cnt_down_valid_i ( cnt_down_valid_i ),
    .cnt_down_id_i    ( cnt_down_id_i    )
  );

endmodule

//--- rtl/llc_hit_miss_ctrl.sv
`timescale 1ns/10ps

module llc_hit_miss_ctrl (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           valid_i,
  output logic           ready_o,
  input  llc_pkg::addr_t desc_addr_i,
  input  llc_pkg::id_t   desc_id_i,
  input  logic           desc_write_i,
  output llc_pkg::addr_t desc_addr_o,
  output llc_pkg::id_t   desc_id_o,
  output logic           desc_write_o,
  output llc_pkg::way_t  desc_way_o,
  output logic           desc_refill_o,
  output logic           desc_evict_o,
  output llc_pkg::tag_t  desc_evict_tag_o,
  output logic           hit_valid_o,
  input  logic           hit_ready_i,
  output logic           miss_valid_o,
  input  logic           miss_ready_i,
  tag_store_if.ctrl      ts,
  lock_if.ctrl           lk,
  miss_cnt_if.ctrl       mc
);
  import llc_pkg::*;

  // descriptor waiting for its lookup result
  addr_t addr_q;
  id_t   id_q;
  logic  write_q;

  logic  load_desc;
  // result present and nothing blocks it
  logic  offer;
  logic  xfer_hit;
  logic  xfer_miss;

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  // lookup goes out together with the input handshake
  assign ts.req_valid = valid_i;
  assign ts.req_index = desc_addr_i.fields.index;
  assign ts.req_tag   = desc_addr_i.fields.tag;
  assign ts.req_write = desc_write_i;

  // the tag store only takes a lookup once the old result is gone
  assign load_desc = valid_i & ts.req_ready;
  assign ready_o   = load_desc;

  always_ff @(posedge clk_i) begin
    if (load_desc) begin
      addr_q  <= desc_addr_i;
      id_q    <= desc_id_i;
      write_q <= desc_write_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////////////////////////

  // res_valid doubles as the busy flag of the unit
  assign offer = ts.res_valid & ~lk.locked & ~mc.stall;

  // hits of an id with misses in flight follow the miss path
  assign hit_valid_o  = offer & ts.res_hit & ~mc.to_miss;
  assign miss_valid_o = offer & (~ts.res_hit | mc.to_miss);

  assign xfer_hit  = hit_valid_o & hit_ready_i;
  assign xfer_miss = miss_valid_o & miss_ready_i;

  // descriptor leaves, result is consumed
  assign ts.res_ready = xfer_hit | xfer_miss;

  // held fields plus what the lookup decided
  assign desc_addr_o      = addr_q;
  assign desc_id_o        = id_q;
  assign desc_write_o     = write_q;
  assign desc_way_o       = ts.res_way;
  assign desc_refill_o    = ~ts.res_hit;
  assign desc_evict_o     = ts.res_evict;
  assign desc_evict_tag_o = ts.res_evict_tag;

  // line stays locked until a unit downstream releases it
  assign lk.chk_index = addr_q.fields.index;
  assign lk.chk_way   = ts.res_way;
  assign lk.lock_req  = xfer_hit | xfer_miss;

  // miss counting per id
  assign mc.chk_id   = id_q;
  assign mc.up_id    = id_q;
  assign mc.up_valid = xfer_miss;

  // one descriptor never leaves on both ports
  a_one_output : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(hit_valid_o && miss_valid_o)
  ) else $error("hit and miss valid high together");

endmodule

//--- rtl/llc_lock_box.sv
`timescale 1ns/10ps

module llc_lock_box (
  input  logic            clk_i,
  input  logic            rst_n_i,
  lock_if.box             lk,
  input  logic            w_unlock_req_i,
  input  llc_pkg::index_t w_unlock_index_i,
  input  llc_pkg::way_t   w_unlock_way_i,
  output logic            w_unlock_gnt_o,
  input  logic            r_unlock_req_i,
  input  llc_pkg::index_t r_unlock_index_i,
  input  llc_pkg::way_t   r_unlock_way_i,
  output logic            r_unlock_gnt_o
);
  import llc_pkg::*;

  logic [LOCK_ENTRIES-1:0] ent_valid_q;
  index_t                  ent_index_q [LOCK_ENTRIES];
  way_t                    ent_way_q   [LOCK_ENTRIES];

  logic [LOCK_ENTRIES-1:0] chk_hit;
  logic [LOCK_ENTRIES-1:0] unl_hit;
  logic [LOCK_ENTRIES-1:0] alloc_sel;
  logic                    unl_valid;
  index_t                  unl_index;
  way_t                    unl_way;

  // write side has priority, one unlock per cycle
  assign w_unlock_gnt_o = w_unlock_req_i;
  assign r_unlock_gnt_o = r_unlock_req_i & ~w_unlock_req_i;
  assign unl_valid      = w_unlock_req_i | r_unlock_req_i;
  assign unl_index      = w_unlock_req_i ? w_unlock_index_i : r_unlock_index_i;
  assign unl_way        = w_unlock_req_i ? w_unlock_way_i : r_unlock_way_i;

  always_comb begin
    logic found;
    found     = 1'b0;
    alloc_sel = '0;
    for (int e = 0; e < LOCK_ENTRIES; e++) begin
      chk_hit[e] = ent_valid_q[e] & (ent_index_q[e] == lk.chk_index) &
                   (ent_way_q[e] == lk.chk_way);
      unl_hit[e] = ent_valid_q[e] & unl_valid & (ent_index_q[e] == unl_index) &
                   (ent_way_q[e] == unl_way);
      // first free slot takes the next lock
      if (!ent_valid_q[e] && !found) begin
        alloc_sel[e] = 1'b1;
        found        = 1'b1;
      end
    end
  end

  // a full table blocks everything
  assign lk.locked = (|chk_hit) | (&ent_valid_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ent_valid_q <= '0;
    end else begin
      ent_valid_q <= (ent_valid_q & ~unl_hit) | (alloc_sel & {LOCK_ENTRIES{lk.lock_req}});
    end
  end

  always_ff @(posedge clk_i) begin
    for (int e = 0; e < LOCK_ENTRIES; e++) begin
      if (lk.lock_req && alloc_sel[e]) begin
        ent_index_q[e] <= lk.chk_index;
        ent_way_q[e]   <= lk.chk_way;
      end
    end
  end

  // controller must wait out a locked line before it sends the descriptor
  a_no_lock_when_locked : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    lk.lock_req |-> !lk.locked
  ) else $error("lock request on a locked line");

endmodule

//--- rtl/llc_miss_counters.sv
`timescale 1ns/10ps

module llc_miss_counters (
  input  logic         clk_i,
  input  logic         rst_n_i,
  miss_cnt_if.cnt      mc,
  input  logic         cnt_down_valid_i,
  input  llc_pkg::id_t cnt_down_id_i
);
  import llc_pkg::*;

  cnt_t               cnt_q [NUM_IDS];
  logic [NUM_IDS-1:0] inc;
  logic [NUM_IDS-1:0] dec;

  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      inc[i] = mc.up_valid & (mc.up_id == id_t'(i));
      dec[i] = cnt_down_valid_i & (cnt_down_id_i == id_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '{default: '0};
    end else begin
      // up and down on the same id cancel out
      for (int i = 0; i < NUM_IDS; i++) begin
        case ({inc[i], dec[i]})
          2'b10:   cnt_q[i] <= cnt_q[i] + 1'b1;
          2'b01:   cnt_q[i] <= cnt_q[i] - 1'b1;
          default: cnt_q[i] <= cnt_q[i];
        endcase
      end
    end
  end

  assign mc.to_miss = (cnt_q[mc.chk_id] != '0);
  assign mc.stall   = (cnt_q[mc.chk_id] == cnt_t'(MAX_MISS));

  a_no_underflow : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cnt_down_valid_i |-> (cnt_q[cnt_down_id_i] != '0)
  ) else $error("count-down on an idle id");

  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mc.up_valid |-> (cnt_q[mc.up_id] != cnt_t'(MAX_MISS))
  ) else $error("miss sent while its id is stalled");

endmodule

//--- rtl/llc_tag_store.sv
`timescale 1ns/10ps

module llc_tag_store (
  input  logic       clk_i,
  input  logic       rst_n_i,
  tag_store_if.store ts
);
  import llc_pkg::*;

  // storage arrays, valid and dirty cleared by the init sweep
  tag_t   tag_q   [NUM_SETS][NUM_WAYS];
  way_t   valid_q [NUM_SETS];
  way_t   dirty_q [NUM_SETS];

  // init sweep state
  index_t init_idx_q;
  logic   init_done_q;
  // one-hot replacement pointer, shared by all sets
  way_t   rr_q;

  // registered lookup result
  logic   res_valid_q;
  logic   res_hit_q;
  way_t   res_way_q;
  logic   res_evict_q;
  tag_t   res_evict_tag_q;

  logic   req_fire;
  way_t   set_valid;
  way_t   set_dirty;
  way_t   hit_vec;
  logic   hit;
  logic   all_valid;
  way_t   victim;
  tag_t   victim_tag;

  assign ts.req_ready = init_done_q & (~res_valid_q | ts.res_ready);
  assign req_fire     = ts.req_valid & ts.req_ready;

  //////////////////////////////////////////////////////////////////////
  // lookup and victim choice
  //////////////////////////////////////////////////////////////////////

  assign set_valid = valid_q[ts.req_index];
  assign set_dirty = dirty_q[ts.req_index];
  assign all_valid = &set_valid;
  assign hit       = |hit_vec;

  always_comb begin
    hit_vec    = '0;
    victim_tag = '0;
    // full set falls back to the pointer
    victim     = rr_q;
    // walk down so the lowest invalid way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!set_valid[w]) begin
        victim = way_t'(1) << w;
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = set_valid[w] & (tag_q[ts.req_index][w] == ts.req_tag);
      if (victim[w]) begin
        victim_tag = tag_q[ts.req_index][w];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // array update and result capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!init_done_q) begin
      valid_q[init_idx_q] <= '0;
      dirty_q[init_idx_q] <= '0;
    end else if (req_fire) begin
      if (hit) begin
        // write hit only sets dirty
        if (ts.req_write) begin
          dirty_q[ts.req_index] <= set_dirty | hit_vec;
        end
      end else begin
        // refill allocates the victim with the new tag
        valid_q[ts.req_index] <= set_valid | victim;
        dirty_q[ts.req_index] <= ts.req_write ? (set_dirty | victim) : (set_dirty & ~victim);
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (victim[w]) begin
            tag_q[ts.req_index][w] <= ts.req_tag;
          end
        end
      end
    end
    if (req_fire) begin
      res_hit_q       <= hit;
      res_way_q       <= hit ? hit_vec : victim;
      // old line goes back only if it was valid and dirty
      res_evict_q     <= ~hit & |(victim & set_valid & set_dirty);
      res_evict_tag_q <= victim_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      init_idx_q  <= '0;
      init_done_q <= 1'b0;
      rr_q        <= way_t'(1);
      res_valid_q <= 1'b0;
    end else begin
      // one set per cycle, done after the last one
      if (!init_done_q) begin
        init_idx_q <= init_idx_q + 1'b1;
        if (init_idx_q == index_t'(NUM_SETS - 1)) begin
          init_done_q <= 1'b1;
        end
      end
      res_valid_q <= req_fire | (res_valid_q & ~ts.res_ready);
      // pointer moves only when it was actually used
      if (req_fire && !hit && all_valid) begin
        rr_q <= {rr_q[NUM_WAYS-2:0], rr_q[NUM_WAYS-1]};
      end
    end
  end

  assign ts.res_valid     = res_valid_q;
  assign ts.res_hit       = res_hit_q;
  assign ts.res_way       = res_way_q;
  assign ts.res_evict     = res_evict_q;
  assign ts.res_evict_tag = res_evict_tag_q;

  // no duplicate tags in a set, so the way must name one line
  a_way_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    res_valid_q |-> $onehot(res_way_q)
  ) else $error("result way is not one-hot");

endmodule

//--- sources.f
+incdir+testbench
common/llc_pkg.sv
common/tag_store_if.sv
common/lock_if.sv
common/miss_cnt_if.sv
rtl/llc_hit_miss_ctrl.sv
rtl/llc_tag_store.sv
rtl/llc_lock_box.sv
rtl/llc_miss_counters.sv
rtl/llc_hit_miss.sv
testbench/tb_llc_hit_miss.sv

//--- testbench/tb_llc_model.svh
`ifndef TB_LLC_MODEL_SVH
`define TB_LLC_MODEL_SVH

// mirror of the tag store contents
tag_t m_tag   [NUM_SETS][NUM_WAYS];
logic m_valid [NUM_SETS][NUM_WAYS];
logic m_dirty [NUM_SETS][NUM_WAYS];
// way index of the shared replacement pointer
int   m_rr;

// prediction for the last access
logic p_hit;
way_t p_way;
logic p_evict;
tag_t p_evict_tag;

function automatic void model_reset();
  for (int s = 0; s < NUM_SETS; s++) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      m_tag[s][w]   = '0;
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
    end
  end
  m_rr = 0;
endfunction

function automatic void model_access(index_t idx, tag_t tag, logic wr);
  int v;
  v       = -1;
  p_hit   = 1'b0;
  p_evict = 1'b0;
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
      p_hit = 1'b1;
      v     = w;
    end
  end
  if (p_hit) begin
    // write hit just marks the line dirty
    if (wr) m_dirty[idx][v] = 1'b1;
  end else begin
    // lowest invalid way first
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_valid[idx][w] && v < 0) v = w;
    end
    // full set, take the pointer and move it on
    if (v < 0) begin
      v    = m_rr;
      m_rr = (m_rr + 1) % NUM_WAYS;
    end
    p_evict     = m_valid[idx][v] & m_dirty[idx][v];
    p_evict_tag = m_tag[idx][v];
    m_tag[idx][v]   = tag;
    m_valid[idx][v] = 1'b1;
    m_dirty[idx][v] = wr;
  end
  p_way = way_t'(1) << v;
endfunction

`endif

//--- testbench/tb_llc_hit_miss.sv
`timescale 1ns/10ps

module tb_llc_hit_miss;
  import llc_pkg::*;

  typedef struct packed {
    index_t   idx;
    tag_t     tag;
    id_t      id;
    logic     wr;
    logic     to_hit;
    // 0 none, 1 read side, 2 write and read together
    int       unl;
    logic     cd;
    id_t      cd_id;
    int       hold;
    // no output for 20 cycles, unlock or count-down then releases it
    logic     blocked;
    // line stays locked after it leaves
    logic     keep;
  } row_t;

  localparam int NROWS       = 19;
  localparam int CYCLE_LIMIT = 16 + 50 * NROWS + 100;

  logic clk_i, rst_n_i, valid_i, ready_o, desc_write_i;
  addr_t desc_addr_i, desc_addr_o, exp_addr;
  id_t desc_id_i, desc_id_o, cnt_down_id_i;
  logic desc_write_o, desc_refill_o, desc_evict_o;
  way_t desc_way_o, w_unlock_way_i, r_unlock_way_i;
  tag_t desc_evict_tag_o;
  logic hit_valid_o, hit_ready_i, miss_valid_o, miss_ready_i;
  logic w_unlock_req_i, w_unlock_gnt_o, r_unlock_req_i, r_unlock_gnt_o;
  index_t w_unlock_index_i, r_unlock_index_i;
  logic cnt_down_valid_i;
  row_t rows [NROWS];
  row_t cur;
  int cycle_cnt, low_cnt, r, n;
  logic accepted, seen;
  int unsigned seed_val;

  `include "tb_llc_model.svh"

  llc_hit_miss i_llc_hit_miss (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic check_id(string name, id_t got, id_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic check_way(string name, way_t got, way_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic check_tag(string name, tag_t got, tag_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  // whole descriptor on the expected port
  task automatic check_outputs();
    check_bit("hit_valid_o", hit_valid_o, cur.to_hit);
    check_bit("miss_valid_o", miss_valid_o, !cur.to_hit);
    check_addr("desc_addr_o", desc_addr_o, exp_addr);
    check_id("desc_id_o", desc_id_o, cur.id);
    check_bit("desc_write_o", desc_write_o, cur.wr);
    check_way("desc_way_o", desc_way_o, p_way);
    check_bit("desc_refill_o", desc_refill_o, !p_hit);
    check_bit("desc_evict_o", desc_evict_o, p_evict);
    if (p_evict) check_tag("desc_evict_tag_o", desc_evict_tag_o, p_evict_tag);
  endtask

  ////////////////////////////////////////////////////////////////////
  // drive helpers, each starts and ends 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////

  task automatic next_drive();
    @(posedge clk_i);
    #1;
  endtask

  task automatic unlock(logic w, logic rd, index_t idx, way_t way);
    w_unlock_req_i   = w;
    w_unlock_index_i = idx;
    w_unlock_way_i   = way;
    r_unlock_req_i   = rd;
    r_unlock_index_i = idx;
    r_unlock_way_i   = way;
    @(negedge clk_i);
    // write side wins when both ask
    check_bit("w_unlock_gnt_o", w_unlock_gnt_o, w);
    check_bit("r_unlock_gnt_o", r_unlock_gnt_o, rd & !w);
    next_drive();
    w_unlock_req_i = 1'b0;
    r_unlock_req_i = 1'b0;
  endtask

  task automatic count_down(id_t id);
    cnt_down_valid_i = 1'b1;
    cnt_down_id_i    = id;
    next_drive();
    cnt_down_valid_i = 1'b0;
  endtask

  task automatic pre_actions();
    if (cur.unl == 1) unlock(1'b0, 1'b1, cur.idx, p_way);
    if (cur.unl == 2) unlock(1'b1, 1'b1, cur.idx, p_way);
    if (cur.cd) count_down(cur.cd_id);
  endtask

  function automatic row_t mk(index_t idx, tag_t tag, id_t id, logic wr, logic to_hit,
                              int unl, logic cd, id_t cd_id, int hold, logic blocked,
                              logic keep);
    row_t x;
    x = '{idx, tag, id, wr, to_hit, unl, cd, cd_id, hold, blocked, keep};
    return x;
  endfunction

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) stop_with_failure("timeout, the run did not finish");
    end
  end

  initial begin
    seed_val = $urandom(66176);
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    desc_addr_i = '0;
    desc_id_i = '0;
    desc_write_i = 1'b0;
    hit_ready_i = 1'b1;
    miss_ready_i = 1'b1;
    w_unlock_req_i = 1'b0;
    w_unlock_index_i = '0;
    w_unlock_way_i = '0;
    r_unlock_req_i = 1'b0;
    r_unlock_index_i = '0;
    r_unlock_way_i = '0;
    cnt_down_valid_i = 1'b0;
    cnt_down_id_i = '0;
    model_reset();

    //     idx  tag      id wr hit unl cd cdid hold blk keep
    rows[0]  = mk(1, 22'h0a1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    rows[1]  = mk(1, 22'h0a1, 1, 0, 1, 0, 0, 0, 0, 0, 0);
    // five writes into set 2
    rows[2]  = mk(2, 22'h100, 2, 1, 0, 0, 0, 0, 0, 0, 0);
    rows[3]  = mk(2, 22'h101, 2, 1, 0, 0, 0, 0, 0, 0, 0);
    rows[4]  = mk(2, 22'h102, 2, 1, 0, 0, 0, 0, 0, 0, 0);
    rows[5]  = mk(2, 22'h103, 2, 1, 0, 0, 0, 0, 0, 0, 0);
    rows[6]  = mk(2, 22'h104, 2, 1, 0, 0, 0, 0, 0, 0, 0);
    rows[7]  = mk(2, 22'h100, 3, 0, 0, 0, 0, 0, 0, 0, 0);
    // lock, then hit on the locked line
    rows[8]  = mk(3, 22'h2b0, 1, 0, 0, 0, 1, 0, 0, 0, 1);
    rows[9]  = mk(3, 22'h2b0, 0, 0, 1, 1, 0, 0, 0, 1, 0);
    rows[10] = mk(1, 22'h0a1, 0, 0, 1, 2, 0, 0, 0, 0, 0);
    // redirection while id 1 has misses in flight
    rows[11] = mk(1, 22'h0a1, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    rows[12] = mk(1, 22'h0a1, 0, 0, 1, 0, 1, 1, 0, 0, 0);
    rows[13] = mk(1, 22'h0a1, 1, 0, 1, 0, 1, 1, 0, 0, 0);
    // id 2 fills up to seven, the eighth waits
    rows[14] = mk(5, 22'h300, 2, 0, 0, 0, 0, 0, 0, 0, 0);
    rows[15] = mk(5, 22'h301, 2, 0, 0, 0, 0, 0, 0, 0, 0);
    rows[16] = mk(5, 22'h302, 2, 0, 0, 0, 1, 2, 0, 1, 0);
    // back-pressure
    rows[17] = mk(1, 22'h0a1, 0, 0, 1, 0, 0, 0, 3, 0, 0);
    rows[18] = mk(6, 22'h3c5, 1, 1, 0, 0, 0, 0, 2, 0, 0);

    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    for (r = 0; r < NROWS; r++) begin
      cur = rows[r];
      model_access(cur.idx, cur.tag, cur.wr);
      if (!cur.blocked) pre_actions();
      exp_addr.fields.tag    = cur.tag;
      exp_addr.fields.index  = cur.idx;
      exp_addr.fields.offset = OFFSET_W'($urandom);
      if (cur.hold > 0) begin
        if (cur.to_hit) hit_ready_i = 1'b0;
        else miss_ready_i = 1'b0;
      end
      valid_i      = 1'b1;
      desc_addr_i  = exp_addr;
      desc_id_i    = cur.id;
      desc_write_i = cur.wr;
      low_cnt  = 0;
      accepted = 1'b0;
      for (n = 0; n < 40 && !accepted; n++) begin
        @(negedge clk_i);
        // unit is empty until the lookup result comes back
        if (hit_valid_o || miss_valid_o) begin
          stop_with_failure("valid output with no descriptor in the unit");
        end
        if (ready_o) accepted = 1'b1;
        else low_cnt++;
        next_drive();
      end
      valid_i = 1'b0;
      if (!accepted) stop_with_failure("descriptor was never accepted");
      // first row also sees the init sweep
      if (r == 0 && low_cnt != NUM_SETS) stop_with_failure("ready low for wrong cycle count");
      if (cur.blocked) begin
        repeat (20) begin
          @(negedge clk_i);
          if (hit_valid_o || miss_valid_o) stop_with_failure("blocked descriptor came out");
        end
        next_drive();
        pre_actions();
      end
      seen = 1'b0;
      for (n = 0; n < 40 && !seen; n++) begin
        @(negedge clk_i);
        if (cur.to_hit ? miss_valid_o : hit_valid_o) stop_with_failure("descriptor on wrong port");
        if (cur.to_hit ? hit_valid_o : miss_valid_o) seen = 1'b1;
      end
      if (!seen) stop_with_failure("descriptor never left the unit");
      check_outputs();
      if (cur.hold > 0) begin
        // outputs must not move while held off
        repeat (cur.hold) begin
          @(negedge clk_i);
          check_outputs();
        end
        next_drive();
        hit_ready_i  = 1'b1;
        miss_ready_i = 1'b1;
        @(negedge clk_i);
        check_outputs();
      end
      next_drive();
      if (!cur.keep) unlock(1'b1, 1'b0, cur.idx, p_way);
    end

    repeat (2) @(negedge clk_i);
    if (hit_valid_o || miss_valid_o) begin
      stop_with_failure("unexpected valid after the last row");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule
